//--- fetch_decode.f
hdl/fetch_decode_pkg.sv
hdl/prefetch.sv
hdl/byte_fifo.sv
hdl/modrm_decoder.sv
hdl/fetch_decode_top.sv
verification/fetch_decode_assert.sv
verification/fetch_decode_tb.sv

//--- Makefile
TOP := fetch_decode_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f fetch_decode.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/fetch_decode_tb.sv
// Memory model spans the whole 1 MiB space; register inputs change only together with a load
`timescale 1ns/100ps
`default_nettype none

module fetch_decode_tb;

    localparam int clk_period    = 100;
    localparam int total_records = 40 + 32 + 24 + 30 + 32 + 100;
    localparam int spare_records = 40;

    typedef struct packed {
        logic [7:0]  opcode;
        logic        has_modrm;
        logic [7:0]  modrm;
        logic [15:0] displacement;
        logic [15:0] effective_address;
        logic        rm_is_reg;
        logic        bp_as_base;
    } record_t;

    logic                          clk;
    logic                          rst;
    logic                          load_new_ip;
    logic [15:0]                   new_cs;
    logic [15:0]                   new_ip;
    logic                          instr_ack;
    fetch_decode_pkg::instr_word_t instr_data;
    logic [15:0]                   si;
    logic [15:0]                   di;
    logic [15:0]                   bp;
    logic [15:0]                   bx;
    logic                          instr_access;
    logic [18:0]                   instr_addr;
    logic                          decode_valid;
    logic [7:0]                    opcode;
    logic                          has_modrm;
    logic [7:0]                    modrm;
    logic [15:0]                   displacement;
    logic [15:0]                   effective_address;
    logic                          rm_is_reg;
    logic                          bp_as_base;

    logic [7:0] mem [0:1048575];
    record_t    expected [$];
    int         received = 0;
    int         phase_base = 0;
    int         mismatch_count = 0;
    int         other_count = 0;
    int         max_wait = 3;
    string      test_name = "reset fetch";
    logic       verdict_printed = 1'b0;

    fetch_decode_top uut (
        .clk               (clk),
        .rst               (rst),
        .load_new_ip       (load_new_ip),
        .new_cs            (new_cs),
        .new_ip            (new_ip),
        .instr_ack         (instr_ack),
        .instr_data        (instr_data),
        .si                (si),
        .di                (di),
        .bp                (bp),
        .bx                (bx),
        .instr_access      (instr_access),
        .instr_addr        (instr_addr),
        .decode_valid      (decode_valid),
        .opcode            (opcode),
        .has_modrm         (has_modrm),
        .modrm             (modrm),
        .displacement      (displacement),
        .effective_address (effective_address),
        .rm_is_reg         (rm_is_reg),
        .bp_as_base        (bp_as_base)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic logic [7:0] byte_at(input logic [15:0] cs, input logic [15:0] ip);
        logic [19:0] phys;
        phys = {cs, 4'h0} + {4'h0, ip};
        return mem[phys];
    endfunction

    // Arithmetic reg/mem forms 00h-3Fh with low bits 0-3
    function automatic logic opcode_takes_modrm(input logic [7:0] op);
        return op < 8'h40 && op[2:0] < 3'd4;
    endfunction

    function automatic record_t expected_record(input logic [15:0] cs, inout logic [15:0] ip);
        record_t     rec;
        logic [1:0]  md;
        logic [2:0]  rm;
        logic [7:0]  d8;
        logic [15:0] base;
        rec = '0;
        base = 16'h0000;
        rec.opcode = byte_at(cs, ip);
        ip = ip + 16'd1;
        if (opcode_takes_modrm(rec.opcode)) begin
            rec.has_modrm = 1'b1;
            rec.modrm = byte_at(cs, ip);
            ip = ip + 16'd1;
            md = rec.modrm[7:6];
            rm = rec.modrm[2:0];
            if (md == 2'b11) begin
                rec.rm_is_reg = 1'b1;
            end else begin
                if (md == 2'b01) begin
                    d8 = byte_at(cs, ip);
                    rec.displacement = {{8{d8[7]}}, d8};
                    ip = ip + 16'd1;
                end else if (md == 2'b10 || rm == 3'b110) begin
                    rec.displacement = {byte_at(cs, ip + 16'd1), byte_at(cs, ip)};
                    ip = ip + 16'd2;
                end
                case (rm)
                    3'd0:    base = bx + si;
                    3'd1:    base = bx + di;
                    3'd2:    base = bp + si;
                    3'd3:    base = bp + di;
                    3'd4:    base = si;
                    3'd5:    base = di;
                    3'd6:    base = (md == 2'b00) ? 16'h0000 : bp;
                    default: base = bx;
                endcase
                rec.effective_address = base + rec.displacement;
                rec.bp_as_base = rm == 3'd2 || rm == 3'd3 || (rm == 3'd6 && md != 2'b00);
            end
        end
        return rec;
    endfunction

    // All 32 mod/rm pairs; displacement bytes keep their random fill
    task automatic place_modrm_forms(input logic [19:0] base);
        logic [19:0] a;
        logic [1:0]  md;
        logic [2:0]  rm;
        int          m;
        int          r;
        a = base;
        for (m = 0; m < 4; m++) begin
            for (r = 0; r < 8; r++) begin
                md = 2'(m);
                rm = 3'(r);
                mem[a] = {2'b00, 3'($urandom_range(7, 0)), 3'($urandom_range(3, 0))};
                mem[a + 20'd1] = {md, 3'($urandom_range(7, 0)), rm};
                if (md == 2'b01) begin
                    a = a + 20'd3;
                end else if (md == 2'b10 || (md == 2'b00 && rm == 3'b110)) begin
                    a = a + 20'd4;
                end else begin
                    a = a + 20'd2;
                end
            end
        end
    endtask

    task automatic place_plain_opcodes(input logic [19:0] base, input int n);
        logic [7:0] op;
        int         k;
        for (k = 0; k < n; k++) begin
            op = 8'($urandom);
            while (opcode_takes_modrm(op)) begin
                op = 8'($urandom);
            end
            mem[base + 20'(k)] = op;
        end
    endtask

    task automatic load_and_expect(input logic [15:0] cs, input logic [15:0] ip, input int n);
        logic [15:0] walk_ip;
        int          k;
        @(posedge clk);
        #1;
        load_new_ip = 1'b1;
        new_cs = cs;
        new_ip = ip;
        si = 16'($urandom);
        di = 16'($urandom);
        bp = 16'($urandom);
        bx = 16'($urandom);
        @(posedge clk);
        #1;
        load_new_ip = 1'b0;
        // Old-stream records were all compared by now
        expected.delete();
        walk_ip = ip;
        for (k = 0; k < n + spare_records; k++) begin
            expected.push_back(expected_record(cs, walk_ip));
        end
        phase_base = received;
    endtask

    task automatic wait_records(input int n);
        while (received < phase_base + n) begin
            @(posedge clk);
        end
    endtask

    // Memory with 0 to max_wait wait cycles per access
    initial begin : memory_model
        int wait_left;
        wait_left = -1;
        instr_ack = 1'b0;
        instr_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (instr_ack) begin
                instr_ack = 1'b0;
                wait_left = -1;
            end else if (instr_access) begin
                if (wait_left < 0) begin
                    wait_left = $urandom_range(max_wait, 0);
                end
                if (wait_left == 0) begin
                    instr_ack = 1'b1;
                    instr_data.bytes.lo = mem[{instr_addr, 1'b0}];
                    instr_data.bytes.hi = mem[{instr_addr, 1'b1}];
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    initial begin : compare
        record_t got;
        record_t want;
        forever begin
            @(negedge clk);
            if (!rst && decode_valid) begin
                got = {opcode, has_modrm, modrm, displacement, effective_address,
                       rm_is_reg, bp_as_base};
                received = received + 1;
                assert (expected.size() != 0) else begin
                    other_count++;
                    $display("Decoder produced a record with none expected in test %s",
                             test_name);
                end
                if (expected.size() != 0) begin
                    want = expected.pop_front();
                    assert (got == want) else begin
                        mismatch_count++;
                        $display("[ERROR] %s: record %0d expected %h actual %h",
                                 test_name, received - phase_base, want, got);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [15:0] walk_ip;
        int          i;
        void'($urandom(32'h969b));
        rst = 1'b1;
        load_new_ip = 1'b0;
        new_cs = 16'h0000;
        new_ip = 16'h0000;
        si = 16'($urandom);
        di = 16'($urandom);
        bp = 16'($urandom);
        bx = 16'($urandom);
        for (i = 0; i < 1048576; i++) begin
            mem[i] = 8'($urandom);
        end
        place_modrm_forms(20'h10100);
        place_plain_opcodes(20'h30000, 24);
        walk_ip = 16'h0000;
        for (i = 0; i < 40 + spare_records; i++) begin
            expected.push_back(expected_record(16'hffff, walk_ip));
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset vector FFFF:0000
        @(negedge clk);
        while (!instr_access) begin
            @(negedge clk);
        end
        assert (instr_addr == 19'h7fff8) else begin
            mismatch_count++;
            $display("[ERROR] %s: first word address expected %h actual %h",
                     test_name, 19'h7fff8, instr_addr);
        end
        wait_records(40);

        test_name = "modrm forms";
        load_and_expect(16'h1000, 16'h0100, 32);
        wait_records(32);

        test_name = "one-byte opcodes";
        load_and_expect(16'h3000, 16'h0000, 24);
        wait_records(24);

        test_name = "odd ip";
        load_and_expect(16'h2000, 16'h0033, 30);
        wait_records(30);

        // Each load lands while a fetch is still waiting for its ack
        test_name = "load mid-stream";
        max_wait = 8;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            while (!(instr_access && !instr_ack)) begin
                @(negedge clk);
            end
            load_and_expect(16'($urandom_range(16'hefff, 16'h4000)), 16'($urandom), 8);
            wait_records(8);
        end

        test_name = "long wait states";
        max_wait = 12;
        load_and_expect(16'h5a00, 16'h1235, 100);
        wait_records(100);

        verdict_printed = 1'b1;
        $display("Summary: %0d records, %0d mismatches, %0d other errors",
                 received, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((total_records * 20 + 200) * clk_period);
        verdict_printed = 1'b1;
        $display("Timeout in test %s after %0d records", test_name, received);
        $display("Summary: %0d records, %0d mismatches, %0d other errors",
                 received, mismatch_count, other_count);
        $display("test failed");
        $finish;
    end

    // Catches a run stopped by a failing bound assertion
    final begin
        if (!verdict_printed) begin
            $display("Run stopped before the final summary");
            $display("test failed");
        end
    end

endmodule

`default_nettype wire

//--- verification/fetch_decode_assert.sv
// Bus handshake and queue occupancy checks; each bind instance uses only its own group of inputs
`timescale 1ns/100ps
`default_nettype none

module fetch_decode_assert (
    input wire logic                                  clk,
    input wire logic                                  rst,
    input wire logic                                  access,
    input wire logic [fetch_decode_pkg::addr_width-1:0] addr,
    input wire logic                                  ack,
    input wire logic                                  wr_en,
    input wire logic                                  full,
    input wire logic                                  rd_en,
    input wire logic                                  empty
);

    // Request and address hold until the memory answers
    access_held: assert property (@(posedge clk) disable iff (rst)
        access && !ack |=> access && $stable(addr))
        else $error("instr_access or instr_addr changed before instr_ack");

    ack_with_access: assert property (@(posedge clk) disable iff (rst)
        ack |-> access)
        else $error("instr_ack arrived with no access pending");

    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full)
        else $error("Byte written into a full queue");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty)
        else $error("Byte popped from an empty queue");

endmodule

bind prefetch fetch_decode_assert bus_checks (
    .clk    (clk),
    .rst    (rst),
    .access (instr_access),
    .addr   (instr_addr),
    .ack    (instr_ack),
    .wr_en  (1'b0),
    .full   (1'b0),
    .rd_en  (1'b0),
    .empty  (1'b0)
);

bind byte_fifo fetch_decode_assert queue_checks (
    .clk    (clk),
    .rst    (rst),
    .access (1'b0),
    .addr   ('0),
    .ack    (1'b0),
    .wr_en  (wr_en),
    .full   (full),
    .rd_en  (rd_en),
    .empty  (empty)
);

`default_nettype wire

//--- hdl/fetch_decode_top.sv
// Front end top; load_new_ip doubles as queue and decoder flush, register values are sampled live
`timescale 1ns/100ps
`default_nettype none

module fetch_decode_top #(
    parameter int queue_depth           = fetch_decode_pkg::queue_depth_default,
    parameter int nearly_full_threshold = fetch_decode_pkg::nearly_full_default
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    load_new_ip,
    input  wire logic [fetch_decode_pkg::word_width-1:0] new_cs,
    input  wire logic [fetch_decode_pkg::word_width-1:0] new_ip,
    input  wire logic                                    instr_ack,
    input  wire fetch_decode_pkg::instr_word_t           instr_data,
    input  wire logic [fetch_decode_pkg::word_width-1:0] si,
    input  wire logic [fetch_decode_pkg::word_width-1:0] di,
    input  wire logic [fetch_decode_pkg::word_width-1:0] bp,
    input  wire logic [fetch_decode_pkg::word_width-1:0] bx,
    output logic                                         instr_access,
    output logic [fetch_decode_pkg::addr_width-1:0]      instr_addr,
    output logic                                         decode_valid,
    output logic [7:0]                                   opcode,
    output logic                                         has_modrm,
    output logic [7:0]                                   modrm,
    output logic [fetch_decode_pkg::word_width-1:0]      displacement,
    output logic [fetch_decode_pkg::word_width-1:0]      effective_address,
    output logic                                         rm_is_reg,
    output logic                                         bp_as_base
);

    logic       fifo_wr_en;
    logic [7:0] fifo_wr_data;
    logic       fifo_rd_en;
    logic [7:0] fifo_rd_data;
    logic       fifo_empty;
    logic       fifo_nearly_full;

    prefetch u_prefetch (
        .clk              (clk),
        .rst              (rst),
        .load_new_ip      (load_new_ip),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .instr_ack        (instr_ack),
        .instr_data       (instr_data),
        .fifo_nearly_full (fifo_nearly_full),
        .instr_access     (instr_access),
        .instr_addr       (instr_addr),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data)
    );

    byte_fifo #(
        .depth                 (queue_depth),
        .nearly_full_threshold (nearly_full_threshold)
    ) u_byte_fifo (
        .clk         (clk),
        .rst         (rst),
        .flush       (load_new_ip),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    modrm_decoder u_modrm_decoder (
        .clk               (clk),
        .rst               (rst),
        .flush             (load_new_ip),
        .fifo_rd_data      (fifo_rd_data),
        .fifo_empty        (fifo_empty),
        .si                (si),
        .di                (di),
        .bp                (bp),
        .bx                (bx),
        .fifo_rd_en        (fifo_rd_en),
        .decode_valid      (decode_valid),
        .opcode            (opcode),
        .has_modrm         (has_modrm),
        .modrm             (modrm),
        .displacement      (displacement),
        .effective_address (effective_address),
        .rm_is_reg         (rm_is_reg),
        .bp_as_base        (bp_as_base)
    );

endmodule

`default_nettype wire

//--- hdl/modrm_decoder.sv
// Only 00h-3Fh with low bits 0-3 take ModRM; no immediates or prefixes, records have no back-pressure
`timescale 1ns/100ps
`default_nettype none

module modrm_decoder (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        flush,
    input  wire logic [7:0]  fifo_rd_data,
    input  wire logic        fifo_empty,
    input  wire logic [15:0] si,
    input  wire logic [15:0] di,
    input  wire logic [15:0] bp,
    input  wire logic [15:0] bx,
    output logic             fifo_rd_en,
    output logic             decode_valid,
    output logic [7:0]       opcode,
    output logic             has_modrm,
    output logic [7:0]       modrm,
    output logic [15:0]      displacement,
    output logic [15:0]      effective_address,
    output logic             rm_is_reg,
    output logic             bp_as_base
);

    typedef enum logic [1:0] {
        st_opcode,
        st_modrm,
        st_disp_lo,
        st_disp_hi
    } state_t;

    state_t      state;
    logic [7:0]  opcode_r;
    logic [7:0]  modrm_r;
    logic [7:0]  disp_lo_r;
    logic [7:0]  cur_modrm;
    logic [1:0]  mod;
    logic [2:0]  rm;
    logic        opcode_has_modrm;
    logic        needs_disp;
    logic        record_done;
    logic        one_byte;
    logic        is_reg;
    logic        bp_based;
    logic [15:0] disp_value;
    logic [15:0] base_sum;

    assign fifo_rd_en = !fifo_empty && !flush;

    assign opcode_has_modrm = fifo_rd_data[7:6] == 2'b00 && !fifo_rd_data[2];

    // ModRM byte is on the queue head while in st_modrm
    assign cur_modrm = (state == st_modrm) ? fifo_rd_data : modrm_r;
    assign mod       = cur_modrm[7:6];
    assign rm        = cur_modrm[2:0];
    assign is_reg    = mod == fetch_decode_pkg::mod_register;
    assign one_byte  = state == st_opcode;

    assign needs_disp = mod == fetch_decode_pkg::mod_disp8 ||
                        mod == fetch_decode_pkg::mod_disp16 ||
                        (mod == fetch_decode_pkg::mod_direct &&
                         rm == fetch_decode_pkg::rm_bp_direct);

    always_comb begin
        case (state)
            st_opcode:  record_done = !opcode_has_modrm;
            st_modrm:   record_done = !needs_disp;
            st_disp_lo: record_done = mod == fetch_decode_pkg::mod_disp8;
            default:    record_done = 1'b1;
        endcase
        record_done = record_done && fifo_rd_en;
    end

    always_comb begin
        case (state)
            st_disp_lo: disp_value = {{8{fifo_rd_data[7]}}, fifo_rd_data};
            st_disp_hi: disp_value = {fifo_rd_data, disp_lo_r};
            default:    disp_value = 16'h0000;
        endcase
    end

    // 8086 base/index table
    always_comb begin
        case (rm)
            fetch_decode_pkg::rm_bx_si:     base_sum = bx + si;
            fetch_decode_pkg::rm_bx_di:     base_sum = bx + di;
            fetch_decode_pkg::rm_bp_si:     base_sum = bp + si;
            fetch_decode_pkg::rm_bp_di:     base_sum = bp + di;
            fetch_decode_pkg::rm_si:        base_sum = si;
            fetch_decode_pkg::rm_di:        base_sum = di;
            fetch_decode_pkg::rm_bp_direct:
                base_sum = (mod == fetch_decode_pkg::mod_direct) ? 16'h0000 : bp;
            fetch_decode_pkg::rm_bx:        base_sum = bx;
        endcase
    end

    assign bp_based = !is_reg &&
                      (rm == fetch_decode_pkg::rm_bp_si ||
                       rm == fetch_decode_pkg::rm_bp_di ||
                       (rm == fetch_decode_pkg::rm_bp_direct &&
                        mod != fetch_decode_pkg::mod_direct));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state        <= st_opcode;
            decode_valid <= 1'b0;
        end else begin
            decode_valid <= record_done;
            if (fifo_rd_en) begin
                case (state)
                    st_opcode:  state <= opcode_has_modrm ? st_modrm : st_opcode;
                    st_modrm:   state <= needs_disp ? st_disp_lo : st_opcode;
                    st_disp_lo: state <= record_done ? st_opcode : st_disp_hi;
                    default:    state <= st_opcode;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            case (state)
                st_opcode:  opcode_r  <= fifo_rd_data;
                st_modrm:   modrm_r   <= fifo_rd_data;
                st_disp_lo: disp_lo_r <= fifo_rd_data;
                default:    disp_lo_r <= disp_lo_r;
            endcase
        end
        if (record_done) begin
            opcode            <= one_byte ? fifo_rd_data : opcode_r;
            has_modrm         <= !one_byte;
            modrm             <= one_byte ? 8'h00 : cur_modrm;
            rm_is_reg         <= !one_byte && is_reg;
            bp_as_base        <= !one_byte && bp_based;
            displacement      <= (one_byte || is_reg) ? 16'h0000 : disp_value;
            effective_address <= (one_byte || is_reg) ? 16'h0000 : base_sum + disp_value;
        end
    end

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
// Byte queue of any depth >= 2; writes when full and reads when empty are ignored, flush beats both
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
    parameter int depth                 = 6,
    parameter int nearly_full_threshold = 2
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       flush,
    input  wire logic       wr_en,
    input  wire logic [7:0] wr_data,
    input  wire logic       rd_en,
    output logic [7:0]      rd_data,
    output logic            empty,
    output logic            nearly_full
);

    localparam int ptr_width   = $clog2(depth);
    localparam int count_width = $clog2(depth + 1);
    localparam logic [ptr_width-1:0]   last_idx   = ptr_width'(depth - 1);
    localparam logic [count_width-1:0] full_count = count_width'(depth);
    localparam logic [count_width-1:0] nf_count   =
        count_width'(depth - nearly_full_threshold);

    logic [7:0]             mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   full;
    logic                   do_write;
    logic                   do_read;

    assign full        = count == full_count;
    assign empty       = count == '0;
    assign nearly_full = count >= nf_count;
    assign rd_data     = mem[rd_ptr];

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write && !flush) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/prefetch.sv
// Single outstanding fetch; queue must keep two free bytes when nearly_full drops, CS:IP wraps at 1 MiB
`timescale 1ns/100ps
`default_nettype none

module prefetch (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire logic                                  load_new_ip,
    input  wire logic [fetch_decode_pkg::word_width-1:0] new_cs,
    input  wire logic [fetch_decode_pkg::word_width-1:0] new_ip,
    input  wire logic                                  instr_ack,
    input  wire fetch_decode_pkg::instr_word_t         instr_data,
    input  wire logic                                  fifo_nearly_full,
    output logic                                       instr_access,
    output logic [fetch_decode_pkg::addr_width-1:0]    instr_addr,
    output logic                                       fifo_wr_en,
    output logic [7:0]                                 fifo_wr_data
);

    logic [fetch_decode_pkg::word_width-1:0] cs;
    logic [fetch_decode_pkg::word_width-1:0] ip;
    logic [fetch_decode_pkg::word_width-1:0] addr_cs;
    logic [fetch_decode_pkg::word_width-1:0] addr_ip;
    logic [fetch_decode_pkg::addr_width:0]   phys_addr;
    fetch_decode_pkg::instr_word_t           fetched;
    logic                                    writing;
    logic                                    byte_sel;
    logic                                    discard;

    // A load redirects the address of an access started in the same cycle
    assign addr_cs   = load_new_ip ? new_cs : cs;
    assign addr_ip   = load_new_ip ? new_ip : ip;
    assign phys_addr = {addr_cs, 4'b0000} + {4'b0000, addr_ip};

    assign fifo_wr_en   = writing;
    assign fifo_wr_data = byte_sel ? fetched.bytes.hi : fetched.bytes.lo;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs           <= 16'hffff;
            ip           <= 16'h0000;
            instr_access <= 1'b0;
            writing      <= 1'b0;
            byte_sel     <= 1'b0;
            discard      <= 1'b0;
        end else if (load_new_ip) begin
            cs      <= new_cs;
            ip      <= new_ip;
            writing <= 1'b0;
            if (instr_access && !instr_ack) begin
                // Let the old access finish, then drop its word
                discard <= 1'b1;
            end else begin
                instr_access <= 1'b1;
                discard      <= 1'b0;
            end
        end else begin
            if (instr_access && instr_ack) begin
                instr_access <= 1'b0;
                if (discard) begin
                    discard <= 1'b0;
                end else begin
                    writing  <= 1'b1;
                    // Odd IP skips the low byte
                    byte_sel <= ip[0];
                end
            end else if (!instr_access && !writing && !fifo_nearly_full) begin
                instr_access <= 1'b1;
            end
            if (writing) begin
                ip <= ip + 16'd1;
                if (byte_sel) begin
                    writing <= 1'b0;
                end else begin
                    byte_sel <= 1'b1;
                end
            end
        end
    end

    // Address and word are captured only when their event occurs
    always_ff @(posedge clk) begin
        if (!instr_access || instr_ack) begin
            instr_addr <= phys_addr[fetch_decode_pkg::addr_width:1];
        end
        if (instr_access && instr_ack) begin
            fetched.word <= instr_data.word;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_decode_pkg.sv
// Shared widths and encodings for the front end; real-mode 20-bit addressing with 16-bit words only
`default_nettype none

package fetch_decode_pkg;

    // Bus and register word width
    localparam int word_width = 16;

    // Word address, physical address bits 19:1
    localparam int addr_width = 19;

    // Bus word, seen whole or as the two bytes pushed into the queue
    typedef union packed {
        logic [word_width-1:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } instr_word_t;

    // ModRM mod field
    localparam logic [1:0] mod_direct   = 2'b00;
    localparam logic [1:0] mod_disp8    = 2'b01;
    localparam logic [1:0] mod_disp16   = 2'b10;
    localparam logic [1:0] mod_register = 2'b11;

    // rm code for BP, or a direct address when mod is 00
    localparam logic [2:0] rm_bp_direct = 3'b110;

    // Base/index pairs of the 8086 address table
    localparam logic [2:0] rm_bx_si = 3'b000;
    localparam logic [2:0] rm_bx_di = 3'b001;
    localparam logic [2:0] rm_bp_si = 3'b010;
    localparam logic [2:0] rm_bp_di = 3'b011;
    localparam logic [2:0] rm_si    = 3'b100;
    localparam logic [2:0] rm_di    = 3'b101;
    localparam logic [2:0] rm_bx    = 3'b111;

    // Top-level parameter defaults
    localparam int queue_depth_default = 6;
    localparam int nearly_full_default = 2;

endpackage

`default_nettype wire
